//--- hw/a2_card_pkg.sv
package a2_card_pkg;

    // Apple II bus widths
    localparam int A2_DATA_W = 8;
    localparam int A2_ADDR_W = 16;

    // Speaker soft switch, any access toggles the cone
    localparam logic [A2_ADDR_W-1:0] SPEAKER_ADDR = 16'hC030;

    // Audio and video sample widths
    localparam int AUDIO_W    = 16;
    localparam int MB_AUDIO_W = 10;
    localparam int COLOR_W    = 8;

    // Bus timing seen from the logic clock domain
    typedef struct packed {
        logic phi0;
        logic phi1;
        logic phi1_posedge;
        logic phi1_negedge;
        logic clk_2m_posedge;
        logic clk_7m;
        logic clk_7m_posedge;
        logic clk_7m_negedge;
        logic clk_14m_posedge;
    } a2_clk_t;

    // One slot card's answer to a bus cycle
    typedef struct packed {
        logic                 rd_en;
        logic                 irq_n;
        logic [A2_DATA_W-1:0] data;
    } card_resp_t;

    // Stereo sample
    typedef struct packed {
        logic [AUDIO_W-1:0] left;
        logic [AUDIO_W-1:0] right;
    } audio_frame_t;

    typedef struct packed {
        logic [COLOR_W-1:0] r;
        logic [COLOR_W-1:0] g;
        logic [COLOR_W-1:0] b;
    } rgb_t;

endpackage

//--- hw/a2_clock_sync.sv
`timescale 1ns/1ps

module a2_clock_sync import a2_card_pkg::*; (
    input  logic    clk_logic_w,
    input  logic    rst_n_i,
    input  logic    a2_phi1_i,
    input  logic    a2_7m_i,
    output a2_clk_t a2_clk_o
);

    // Bit 0 carries phi1, bit 1 carries 7M
    logic [1:0] meta_q;
    logic [1:0] sync_q;
    logic [1:0] prev_q;
    logic [1:0] rise_w;
    logic [1:0] fall_w;

    // Two-flop synchronizer plus one history stage for edge detection
    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            meta_q <= '0;
            sync_q <= '0;
            prev_q <= '0;
        end else begin
            meta_q <= {a2_7m_i, a2_phi1_i};
            sync_q <= meta_q;
            prev_q <= sync_q;
        end
    end

    assign rise_w = sync_q & ~prev_q;
    assign fall_w = ~sync_q & prev_q;

    always_comb begin
        a2_clk_o.phi1            = sync_q[0];
        // Phi0 is the complement of phi1 on the bus
        a2_clk_o.phi0            = ~sync_q[0];
        a2_clk_o.phi1_posedge    = rise_w[0];
        a2_clk_o.phi1_negedge    = fall_w[0];
        a2_clk_o.clk_2m_posedge  = rise_w[0] | fall_w[0];
        a2_clk_o.clk_7m          = sync_q[1];
        a2_clk_o.clk_7m_posedge  = rise_w[1];
        a2_clk_o.clk_7m_negedge  = fall_w[1];
        // Both 7M edges give the 14M tick
        a2_clk_o.clk_14m_posedge = rise_w[1] | fall_w[1];
    end

    // Phi1 strobes are mutually exclusive
    a_phi1_edges_exclusive : assert property (
        @(posedge clk_logic_w) disable iff (!rst_n_i)
        !(a2_clk_o.phi1_posedge && a2_clk_o.phi1_negedge)
    );

endmodule

//--- hw/slot_response_arbiter.sv
`timescale 1ns/1ps

module slot_response_arbiter import a2_card_pkg::*; #(
    parameter int NUM_CARDS           = 4,
    parameter bit BUS_DATA_OUT_ENABLE = 1'b1,
    parameter bit IRQ_OUT_ENABLE      = 1'b1
) (
    input  logic                           clk_logic_w,
    input  logic                           rst_n_i,
    input  card_resp_t [NUM_CARDS-1:0]     cards_i,
    input  logic       [A2_DATA_W-1:0]     bus_data_i,
    output logic                           data_out_en_o,
    output logic       [A2_DATA_W-1:0]     data_out_o,
    output logic                           irq_n_o
);

    logic [A2_DATA_W-1:0] sel_data_w;
    logic                 any_rd_w;
    logic                 irq_all_n_w;

    // Walk from lowest priority up so card 0 wins last
    always_comb begin
        sel_data_w  = bus_data_i;
        any_rd_w    = 1'b0;
        irq_all_n_w = 1'b1;
        for (int i = NUM_CARDS - 1; i >= 0; i--) begin
            if (cards_i[i].rd_en) begin
                sel_data_w = cards_i[i].data;
                any_rd_w   = 1'b1;
            end
            // Open-drain lines, any card pulls low
            irq_all_n_w = irq_all_n_w & cards_i[i].irq_n;
        end
    end

    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data_out_en_o <= 1'b0;
            data_out_o    <= '0;
            irq_n_o       <= 1'b1;
        end else begin
            data_out_en_o <= any_rd_w & BUS_DATA_OUT_ENABLE;
            data_out_o    <= sel_data_w;
            irq_n_o       <= irq_all_n_w | ~IRQ_OUT_ENABLE;
        end
    end

    // Interrupt line never driven when disabled
    a_irq_disabled_high : assert property (
        @(posedge clk_logic_w) disable iff (!rst_n_i)
        !IRQ_OUT_ENABLE |-> irq_n_o
    );

endmodule

//--- hw/apple_speaker.sv
`timescale 1ns/1ps

module apple_speaker import a2_card_pkg::*; (
    input  logic                 clk_logic_w,
    input  logic                 rst_n_i,
    input  a2_clk_t              a2_clk_i,
    input  logic [A2_ADDR_W-1:0] a2_addr_i,
    input  logic                 enable_i,
    output logic                 speaker_o
);

    logic speaker_hit_w;
    logic speaker_q;

    // Address is valid at the start of phi1
    assign speaker_hit_w = a2_clk_i.phi1_posedge && (a2_addr_i == SPEAKER_ADDR);

    // Each access to the soft switch flips the cone position
    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            speaker_q <= 1'b0;
        end else if (speaker_hit_w) begin
            speaker_q <= ~speaker_q;
        end
    end

    assign speaker_o = speaker_q & enable_i;

endmodule

//--- hw/audio_mixer.sv
`timescale 1ns/1ps

module audio_mixer import a2_card_pkg::*; (
    input  logic                  clk_logic_w,
    input  logic                  rst_n_i,
    input  logic [AUDIO_W-1:0]    sprite_audio_i,
    input  logic [MB_AUDIO_W-1:0] mb_audio_l_i,
    input  logic [MB_AUDIO_W-1:0] mb_audio_r_i,
    input  logic                  speaker_i,
    output audio_frame_t          audio_o
);

    logic [AUDIO_W-1:0] mb_l_scaled_w;
    logic [AUDIO_W-1:0] mb_r_scaled_w;
    logic [AUDIO_W-1:0] speaker_scaled_w;
    logic [AUDIO_W-1:0] mix_l_w;
    logic [AUDIO_W-1:0] mix_r_w;

    // Mockingboard sits five bits up, speaker is a fixed step at bit 13
    assign mb_l_scaled_w    = AUDIO_W'(mb_audio_l_i) << 5;
    assign mb_r_scaled_w    = AUDIO_W'(mb_audio_r_i) << 5;
    assign speaker_scaled_w = AUDIO_W'(speaker_i) << 13;

    // Sums wrap at 16 bits
    assign mix_l_w = sprite_audio_i + mb_l_scaled_w + speaker_scaled_w;
    assign mix_r_w = sprite_audio_i + mb_r_scaled_w + speaker_scaled_w;

    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            audio_o <= '0;
        end else begin
            audio_o.left  <= mix_l_w;
            audio_o.right <= mix_r_w;
        end
    end

endmodule

//--- hw/scanline_dimmer.sv
`timescale 1ns/1ps

module scanline_dimmer import a2_card_pkg::*; (
    input  logic       clk_logic_w,
    input  logic       rst_n_i,
    input  rgb_t       rgb_i,
    input  logic [9:0] screen_y_i,
    input  logic       scanlines_en_i,
    output rgb_t       rgb_o
);

    logic dim_w;
    rgb_t rgb_dim_w;

    // Odd lines are dimmed
    assign dim_w = scanlines_en_i & screen_y_i[0];

    // Half brightness per channel
    assign rgb_dim_w.r = rgb_i.r >> 1;
    assign rgb_dim_w.g = rgb_i.g >> 1;
    assign rgb_dim_w.b = rgb_i.b >> 1;

    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rgb_o <= '0;
        end else if (dim_w) begin
            rgb_o <= rgb_dim_w;
        end else begin
            rgb_o <= rgb_i;
        end
    end

endmodule

//--- hw/a2_card_glue_top.sv
`timescale 1ns/1ps

module a2_card_glue_top import a2_card_pkg::*; #(
    parameter int NUM_CARDS           = 4,
    parameter bit BUS_DATA_OUT_ENABLE = 1'b1,
    parameter bit IRQ_OUT_ENABLE      = 1'b1
) (
    input  logic                        clk_logic_w,
    input  logic                        rst_n_i,

    // Apple II bus
    input  logic                        a2_phi1_i,
    input  logic                        a2_7m_i,
    input  logic       [A2_ADDR_W-1:0]  a2_addr_i,
    input  logic       [A2_DATA_W-1:0]  a2_data_i,

    // Slot card answers
    input  card_resp_t [NUM_CARDS-1:0]  cards_i,

    // Audio sources
    input  logic                        speaker_en_i,
    input  logic       [AUDIO_W-1:0]    sprite_audio_i,
    input  logic       [MB_AUDIO_W-1:0] mb_audio_l_i,
    input  logic       [MB_AUDIO_W-1:0] mb_audio_r_i,

    // Video
    input  rgb_t                        rgb_i,
    input  logic       [9:0]            screen_y_i,
    input  logic                        scanlines_en_i,

    output a2_clk_t                     a2_clk_o,
    output logic                        data_out_en_o,
    output logic       [A2_DATA_W-1:0]  data_out_o,
    output logic                        irq_n_o,
    output audio_frame_t                audio_o,
    output rgb_t                        rgb_o
);

    a2_clk_t a2_clk_w;
    logic    speaker_w;

    assign a2_clk_o = a2_clk_w;

    // Bus clocks into the logic domain
    a2_clock_sync i_a2_clock_sync (
        .clk_logic_w (clk_logic_w),
        .rst_n_i     (rst_n_i),
        .a2_phi1_i   (a2_phi1_i),
        .a2_7m_i     (a2_7m_i),
        .a2_clk_o    (a2_clk_w)
    );

    slot_response_arbiter #(
        .NUM_CARDS           (NUM_CARDS),
        .BUS_DATA_OUT_ENABLE (BUS_DATA_OUT_ENABLE),
        .IRQ_OUT_ENABLE      (IRQ_OUT_ENABLE)
    ) i_slot_response_arbiter (
        .clk_logic_w   (clk_logic_w),
        .rst_n_i       (rst_n_i),
        .cards_i       (cards_i),
        .bus_data_i    (a2_data_i),
        .data_out_en_o (data_out_en_o),
        .data_out_o    (data_out_o),
        .irq_n_o       (irq_n_o)
    );

    apple_speaker i_apple_speaker (
        .clk_logic_w (clk_logic_w),
        .rst_n_i     (rst_n_i),
        .a2_clk_i    (a2_clk_w),
        .a2_addr_i   (a2_addr_i),
        .enable_i    (speaker_en_i),
        .speaker_o   (speaker_w)
    );

    // Speaker joins the sprite and Mockingboard mix
    audio_mixer i_audio_mixer (
        .clk_logic_w    (clk_logic_w),
        .rst_n_i        (rst_n_i),
        .sprite_audio_i (sprite_audio_i),
        .mb_audio_l_i   (mb_audio_l_i),
        .mb_audio_r_i   (mb_audio_r_i),
        .speaker_i      (speaker_w),
        .audio_o        (audio_o)
    );

    scanline_dimmer i_scanline_dimmer (
        .clk_logic_w    (clk_logic_w),
        .rst_n_i        (rst_n_i),
        .rgb_i          (rgb_i),
        .screen_y_i     (screen_y_i),
        .scanlines_en_i (scanlines_en_i),
        .rgb_o          (rgb_o)
    );

endmodule

//--- verification/tb_a2_card_model.svh
`ifndef TB_A2_CARD_MODEL_SVH
`define TB_A2_CARD_MODEL_SVH

// Lowest index that reads wins, the bus data passes when nobody answers
function automatic logic [A2_DATA_W-1:0] model_read_data(
    input card_resp_t [NUM_CARDS-1:0] resp,
    input logic [A2_DATA_W-1:0]       bus_data
);
    logic [A2_DATA_W-1:0] result;
    logic                 found;
    result = bus_data;
    found  = 1'b0;
    for (int i = 0; i < NUM_CARDS; i++) begin
        if (!found && resp[i].rd_en) begin
            result = resp[i].data;
            found  = 1'b1;
        end
    end
    return result;
endfunction

function automatic logic model_read_enable(input card_resp_t [NUM_CARDS-1:0] resp);
    logic any_rd;
    any_rd = 1'b0;
    for (int i = 0; i < NUM_CARDS; i++) begin
        any_rd = any_rd | resp[i].rd_en;
    end
    return any_rd;
endfunction

// Wired-AND of the open-drain interrupt lines
function automatic logic model_irq_n(input card_resp_t [NUM_CARDS-1:0] resp);
    logic all_high;
    all_high = 1'b1;
    for (int i = 0; i < NUM_CARDS; i++) begin
        all_high = all_high & resp[i].irq_n;
    end
    return all_high;
endfunction

// Mockingboard weighs 32, speaker weighs 8192, result wraps at 16 bits
function automatic logic [AUDIO_W-1:0] model_mix(
    input logic [AUDIO_W-1:0]    sprite,
    input logic [MB_AUDIO_W-1:0] mb,
    input logic                  spk
);
    logic [31:0] total;
    total = 32'(sprite) + 32'(mb) * 32 + (spk ? 32'h2000 : 32'h0);
    return total[AUDIO_W-1:0];
endfunction

function automatic rgb_t model_dim_pixel(input rgb_t px, input logic [9:0] line, input logic en);
    rgb_t result;
    result = px;
    if (en && line[0]) begin
        result.r = px.r / 8'd2;
        result.g = px.g / 8'd2;
        result.b = px.b / 8'd2;
    end
    return result;
endfunction

// Bus timing from the current and the previous synchronized levels {7M, phi1}
function automatic a2_clk_t model_bus_clk(input logic [1:0] level, input logic [1:0] last);
    a2_clk_t result;
    result                 = '0;
    result.phi1            = level[0];
    result.phi0            = !level[0];
    result.phi1_posedge    = level[0] && !last[0];
    result.phi1_negedge    = !level[0] && last[0];
    result.clk_2m_posedge  = level[0] != last[0];
    result.clk_7m          = level[1];
    result.clk_7m_posedge  = level[1] && !last[1];
    result.clk_7m_negedge  = !level[1] && last[1];
    result.clk_14m_posedge = level[1] != last[1];
    return result;
endfunction

task automatic compare_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
        $display("TEST FAILED");
        $fatal(1, "Value mismatch on %s", name);
    end
endtask

`endif

//--- verification/tb_a2_card_glue.sv
`timescale 1ns/1ps

module tb_a2_card_glue import a2_card_pkg::*; ();

    localparam int NUM_CARDS    = 4;
    localparam int TARGET_RISES = 40;
    localparam int RUN_TIMEOUT  = 4000;

    logic                       clk_logic_w;
    logic                       rst_n_i;
    logic                       phi1;
    logic                       m7;
    logic [A2_ADDR_W-1:0]       addr;
    logic [A2_DATA_W-1:0]       data;
    card_resp_t [NUM_CARDS-1:0] cards;
    logic                       speaker_en;
    logic [AUDIO_W-1:0]         sprite_audio;
    logic [MB_AUDIO_W-1:0]      mb_l;
    logic [MB_AUDIO_W-1:0]      mb_r;
    rgb_t                       rgb_in;
    logic [9:0]                 screen_y;
    logic                       scanlines_en;

    a2_clk_t                    a2_clk;
    logic                       data_out_en;
    logic [A2_DATA_W-1:0]       data_out;
    logic                       irq_n;
    audio_frame_t               audio;
    rgb_t                       rgb_out;

    int                         seed;
    int                         phi1_cnt;
    int                         m7_cnt;
    int                         driven_rises;
    int                         seen_rises;
    int                         cycles;
    logic                       spk_model;
    logic                       prev_pos;
    logic                       prev_neg;
    logic                       exp_en;
    logic                       exp_irq_n;
    logic [A2_DATA_W-1:0]       exp_data;
    audio_frame_t               exp_audio;
    rgb_t                       exp_rgb;
    a2_clk_t                    exp_clk;
    // Driven {7M, phi1} levels, index 0 is the newest
    logic [1:0]                 bus_hist [3];

    `include "tb_a2_card_model.svh"

    a2_card_glue_top #(.NUM_CARDS(NUM_CARDS)) i_a2_card_glue_top (
        .clk_logic_w    (clk_logic_w),
        .rst_n_i        (rst_n_i),
        .a2_phi1_i      (phi1),
        .a2_7m_i        (m7),
        .a2_addr_i      (addr),
        .a2_data_i      (data),
        .cards_i        (cards),
        .speaker_en_i   (speaker_en),
        .sprite_audio_i (sprite_audio),
        .mb_audio_l_i   (mb_l),
        .mb_audio_r_i   (mb_r),
        .rgb_i          (rgb_in),
        .screen_y_i     (screen_y),
        .scanlines_en_i (scanlines_en),
        .a2_clk_o       (a2_clk),
        .data_out_en_o  (data_out_en),
        .data_out_o     (data_out),
        .irq_n_o        (irq_n),
        .audio_o        (audio),
        .rgb_o          (rgb_out)
    );

    always #4 clk_logic_w = ~clk_logic_w;

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    task drive_payload();
        data = A2_DATA_W'(random_word());
        for (int i = 0; i < NUM_CARDS; i++) begin
            // Sparse reads so the bus pass-through case shows up often
            cards[i].rd_en = ((random_word() & 32'h3) == 32'h0);
            cards[i].irq_n = ((random_word() & 32'h7) != 32'h0);
            cards[i].data  = A2_DATA_W'(random_word());
        end
        speaker_en   = ((random_word() & 32'h7) != 32'h0);
        sprite_audio = AUDIO_W'(random_word());
        mb_l         = MB_AUDIO_W'(random_word());
        mb_r         = MB_AUDIO_W'(random_word());
        rgb_in       = rgb_t'(24'(random_word()));
        screen_y     = 10'(random_word());
        scanlines_en = 1'(random_word());
    endtask

    task drive_bus_clocks();
        if (phi1_cnt == 0) begin
            phi1     = ~phi1;
            // Half period of 4 to 12 cycles
            phi1_cnt = 3 + int'(random_word() % 32'd9);
            if (phi1) begin
                driven_rises++;
            end else if ((random_word() & 32'h3) == 32'h0) begin
                addr = SPEAKER_ADDR;
            end else begin
                addr = A2_ADDR_W'(random_word());
            end
        end else begin
            phi1_cnt--;
        end
        if (m7_cnt == 0) begin
            m7     = ~m7;
            m7_cnt = 1;
        end else begin
            m7_cnt--;
        end
    endtask

    task check_reset_state();
        compare_value("data_out_en_o", 32'(data_out_en), 32'h0);
        compare_value("irq_n_o", 32'(irq_n), 32'h1);
        compare_value("audio_o", 32'(audio), 32'h0);
        compare_value("rgb_o", 32'(rgb_out), 32'h0);
        compare_value("a2_clk_o.phi1_posedge", 32'(a2_clk.phi1_posedge), 32'h0);
    endtask

    task check_outputs();
        compare_value("data_out_o", 32'(data_out), 32'(exp_data));
        compare_value("data_out_en_o", 32'(data_out_en), 32'(exp_en));
        compare_value("irq_n_o", 32'(irq_n), 32'(exp_irq_n));
        compare_value("audio_o.left", 32'(audio.left), 32'(exp_audio.left));
        compare_value("audio_o.right", 32'(audio.right), 32'(exp_audio.right));
        compare_value("rgb_o", 32'(rgb_out), 32'(exp_rgb));
        compare_value("a2_clk_o", 32'(a2_clk), 32'(exp_clk));
        compare_value("a2_clk_o phi1 strobes overlap",
                      32'(a2_clk.phi1_posedge & a2_clk.phi1_negedge), 32'h0);
        compare_value("a2_clk_o.phi1_posedge run", 32'(a2_clk.phi1_posedge & prev_pos), 32'h0);
        compare_value("a2_clk_o.phi1_negedge run", 32'(a2_clk.phi1_negedge & prev_neg), 32'h0);
        prev_pos = a2_clk.phi1_posedge;
        prev_neg = a2_clk.phi1_negedge;
        if (a2_clk.phi1_posedge) begin
            seen_rises++;
        end
    endtask

    // Values the DUT registers on the coming rising edge
    task predict_outputs();
        exp_data        = model_read_data(cards, data);
        exp_en          = model_read_enable(cards);
        exp_irq_n       = model_irq_n(cards);
        exp_audio.left  = model_mix(sprite_audio, mb_l, spk_model & speaker_en);
        exp_audio.right = model_mix(sprite_audio, mb_r, spk_model & speaker_en);
        exp_rgb         = model_dim_pixel(rgb_in, screen_y, scanlines_en);
        // Speaker level flips after the edge that sees the strobe
        if (exp_clk.phi1_posedge && addr == SPEAKER_ADDR) begin
            spk_model = ~spk_model;
        end
        // A level shows two logic clocks after the edge that samples it
        bus_hist[2] = bus_hist[1];
        bus_hist[1] = bus_hist[0];
        bus_hist[0] = {m7, phi1};
        exp_clk     = model_bus_clk(bus_hist[1], bus_hist[2]);
    endtask

    initial begin
        seed         = 85897;
        clk_logic_w  = 1'b0;
        rst_n_i      = 1'b0;
        phi1         = 1'b0;
        m7           = 1'b0;
        addr         = '0;
        data         = '0;
        cards        = '0;
        speaker_en   = 1'b0;
        sprite_audio = '0;
        mb_l         = '0;
        mb_r         = '0;
        rgb_in       = '0;
        screen_y     = '0;
        scanlines_en = 1'b0;
        phi1_cnt     = 3;
        m7_cnt       = 1;
        driven_rises = 0;
        seen_rises   = 0;
        cycles       = 0;
        spk_model    = 1'b0;
        prev_pos     = 1'b0;
        prev_neg     = 1'b0;
        bus_hist     = '{2'b00, 2'b00, 2'b00};
        exp_clk      = model_bus_clk(2'b00, 2'b00);

        // Payload moves during reset and must not reach the outputs
        repeat (9) begin
            @(negedge clk_logic_w);
            check_reset_state();
            drive_payload();
        end
        @(negedge clk_logic_w);
        check_reset_state();
        rst_n_i = 1'b1;
        drive_bus_clocks();
        drive_payload();
        predict_outputs();

        while (seen_rises < TARGET_RISES && cycles < RUN_TIMEOUT) begin
            @(negedge clk_logic_w);
            check_outputs();
            drive_bus_clocks();
            drive_payload();
            predict_outputs();
            cycles++;
        end

        if (seen_rises < TARGET_RISES) begin
            $display("Timeout: only %0d phi1 rise strobes seen after %0d cycles, %0d rises driven",
                     seen_rises, cycles, driven_rises);
            $display("TEST FAILED");
            $fatal(1, "Run timed out waiting for phi1 rise strobes");
        end else if (driven_rises > seen_rises + 1 || seen_rises > driven_rises) begin
            // Synchronizer lag may leave one driven rise not yet seen
            compare_value("a2_clk_o.phi1_posedge count", 32'(seen_rises), 32'(driven_rises));
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- compile.f
+incdir+verification
hw/a2_card_pkg.sv
hw/a2_clock_sync.sv
hw/slot_response_arbiter.sv
hw/apple_speaker.sv
hw/audio_mixer.sv
hw/scanline_dimmer.sv
hw/a2_card_glue_top.sv
verification/tb_a2_card_glue.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_a2_card_glue
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
